// ==== include/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_DATA_W          32
`define CSR_NUM_W           14
`define CSR_SAVE_COUNT      4

// register numbers
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00c
`define CSR_SAVE0           14'h030
`define CSR_TID             14'h040
`define CSR_TCFG            14'h041
`define CSR_TVAL            14'h042
`define CSR_TICLR           14'h044

// field positions
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_CRMD_DA         3
`define CSR_CRMD_PG         4
`define CSR_CRMD_DATF       6:5
`define CSR_CRMD_DATM       8:7
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2
`define CSR_ECFG_LIE        12:0
`define CSR_ESTAT_IS        12:0
`define CSR_ESTAT_IS_SW     1:0
`define CSR_ESTAT_IS_TI     11
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22
`define CSR_EENTRY_VA       31:6
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_TICLR_CLR       0

// exception codes
`define ECODE_INT           6'h00
`define ECODE_ADE           6'h08
`define ECODE_ALE           6'h09
`define ECODE_SYS           6'h0b
`define ECODE_BRK           6'h0c
`define ECODE_INE           6'h0d
`define ESUBCODE_ADEF       9'd0

`define TIMER_IDLE          32'hffff_ffff

`endif

// ==== source/csr_pkg.sv ====
`include "csr_consts.svh"

package csr_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    typedef enum logic [`CSR_NUM_W-1:0] {
        NUM_CRMD   = `CSR_CRMD,
        NUM_PRMD   = `CSR_PRMD,
        NUM_ECFG   = `CSR_ECFG,
        NUM_ESTAT  = `CSR_ESTAT,
        NUM_ERA    = `CSR_ERA,
        NUM_BADV   = `CSR_BADV,
        NUM_EENTRY = `CSR_EENTRY,
        NUM_SAVE0  = `CSR_SAVE0,
        NUM_SAVE1  = `CSR_SAVE0 + 14'd1,
        NUM_SAVE2  = `CSR_SAVE0 + 14'd2,
        NUM_SAVE3  = `CSR_SAVE0 + 14'd3,
        NUM_TID    = `CSR_TID,
        NUM_TCFG   = `CSR_TCFG,
        NUM_TVAL   = `CSR_TVAL,
        NUM_TICLR  = `CSR_TICLR
    } csr_num_e;

    typedef enum logic [5:0] {
        EXC_INT = `ECODE_INT,
        EXC_ADE = `ECODE_ADE,
        EXC_ALE = `ECODE_ALE,
        EXC_SYS = `ECODE_SYS,
        EXC_BRK = `ECODE_BRK,
        EXC_INE = `ECODE_INE
    } ecode_e;

    typedef struct packed {
        logic                   we;
        csr_num_e               num;
        logic [`CSR_DATA_W-1:0] wmask;
        logic [`CSR_DATA_W-1:0] wvalue;
    } csr_req_t;

    // instruction leaving writeback
    typedef struct packed {
        logic                   ex;
        logic                   ertn;
        ecode_e                 ecode;
        logic [8:0]             esubcode;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] vaddr;
    } exc_info_t;

endpackage

// ==== source/csr_exc_regs.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_exc_regs (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_req_t   csr_req,
    input  csr_pkg::exc_info_t  exc,
    input  logic                timer_int,
    output csr_pkg::csr_data_t  rdata,
    output csr_pkg::csr_data_t  ex_entry,
    output csr_pkg::csr_data_t  ex_era,
    output logic                has_int
);

    logic [1:0]         crmd_plv;
    logic               crmd_ie;
    logic               crmd_da;
    logic               crmd_pg;
    logic [1:0]         crmd_datf;
    logic [1:0]         crmd_datm;
    logic [1:0]         prmd_pplv;
    logic               prmd_pie;
    logic [12:0]        ecfg_lie;
    logic [1:0]         estat_is_sw;
    logic [12:0]        estat_is;
    logic [5:0]         estat_ecode;
    logic [8:0]         estat_esubcode;
    csr_pkg::csr_data_t era;
    csr_pkg::csr_data_t badv;
    logic [25:0]        eentry_va;

    csr_pkg::csr_data_t crmd_word, prmd_word, ecfg_word, estat_word, eentry_word;
    csr_pkg::csr_data_t wr_word;
    logic crmd_we, prmd_we, ecfg_we, estat_we, era_we, badv_we, eentry_we;
    logic addr_err;

    assign crmd_we   = csr_req.we && (csr_req.num == csr_pkg::NUM_CRMD);
    assign prmd_we   = csr_req.we && (csr_req.num == csr_pkg::NUM_PRMD);
    assign ecfg_we   = csr_req.we && (csr_req.num == csr_pkg::NUM_ECFG);
    assign estat_we  = csr_req.we && (csr_req.num == csr_pkg::NUM_ESTAT);
    assign era_we    = csr_req.we && (csr_req.num == csr_pkg::NUM_ERA);
    assign badv_we   = csr_req.we && (csr_req.num == csr_pkg::NUM_BADV);
    assign eentry_we = csr_req.we && (csr_req.num == csr_pkg::NUM_EENTRY);

    // merged old/new word of the addressed register
    assign wr_word = (csr_req.wmask & csr_req.wvalue) | (~csr_req.wmask & rdata);

    assign addr_err = (exc.ecode == csr_pkg::EXC_ADE) || (exc.ecode == csr_pkg::EXC_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1; // direct address mode out of reset
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b0;
            crmd_datm <= 2'b0;
        end else if (exc.ex) begin
            crmd_plv <= 2'b0; // kernel, interrupts off
            crmd_ie  <= 1'b0;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv  <= wr_word[`CSR_CRMD_PLV];
            crmd_ie   <= wr_word[`CSR_CRMD_IE];
            crmd_da   <= wr_word[`CSR_CRMD_DA];
            crmd_pg   <= wr_word[`CSR_CRMD_PG];
            crmd_datf <= wr_word[`CSR_CRMD_DATF];
            crmd_datm <= wr_word[`CSR_CRMD_DATM];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (exc.ex) begin
            prmd_pplv <= crmd_plv; // context at entry
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= wr_word[`CSR_PRMD_PPLV];
            prmd_pie  <= wr_word[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie    <= '0;
            estat_is_sw <= '0;
            era         <= '0;
        end else begin
            if (ecfg_we)
                ecfg_lie <= wr_word[`CSR_ECFG_LIE];
            if (estat_we)
                estat_is_sw <= wr_word[`CSR_ESTAT_IS_SW];
            if (exc.ex)
                era <= exc.pc;
            else if (era_we)
                era <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            if (addr_err) begin
                // fetch fault reports the pc itself
                if (exc.ecode == csr_pkg::EXC_ADE && exc.esubcode == `ESUBCODE_ADEF)
                    badv <= exc.pc;
                else
                    badv <= exc.vaddr;
            end
        end else if (badv_we) begin
            badv <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_we)
            eentry_va <= wr_word[`CSR_EENTRY_VA];
    end

    always_comb begin
        estat_is = '0; // no hw or ipi lines
        estat_is[`CSR_ESTAT_IS_SW] = estat_is_sw;
        estat_is[`CSR_ESTAT_IS_TI] = timer_int;

        crmd_word = '0;
        crmd_word[`CSR_CRMD_PLV]  = crmd_plv;
        crmd_word[`CSR_CRMD_IE]   = crmd_ie;
        crmd_word[`CSR_CRMD_DA]   = crmd_da;
        crmd_word[`CSR_CRMD_PG]   = crmd_pg;
        crmd_word[`CSR_CRMD_DATF] = crmd_datf;
        crmd_word[`CSR_CRMD_DATM] = crmd_datm;

        prmd_word = '0;
        prmd_word[`CSR_PRMD_PPLV] = prmd_pplv;
        prmd_word[`CSR_PRMD_PIE]  = prmd_pie;

        ecfg_word = '0;
        ecfg_word[`CSR_ECFG_LIE] = ecfg_lie;

        estat_word = '0;
        estat_word[`CSR_ESTAT_IS]       = estat_is;
        estat_word[`CSR_ESTAT_ECODE]    = estat_ecode;
        estat_word[`CSR_ESTAT_ESUBCODE] = estat_esubcode;

        eentry_word = '0;
        eentry_word[`CSR_EENTRY_VA] = eentry_va; // 64-byte aligned
    end

    always_comb begin
        case (csr_req.num)
            csr_pkg::NUM_CRMD:   rdata = crmd_word;
            csr_pkg::NUM_PRMD:   rdata = prmd_word;
            csr_pkg::NUM_ECFG:   rdata = ecfg_word;
            csr_pkg::NUM_ESTAT:  rdata = estat_word;
            csr_pkg::NUM_ERA:    rdata = era;
            csr_pkg::NUM_BADV:   rdata = badv;
            csr_pkg::NUM_EENTRY: rdata = eentry_word;
            default:             rdata = '0;
        endcase
    end

    assign ex_entry = eentry_word;
    assign ex_era   = era;
    assign has_int  = crmd_ie && ((estat_is[11:0] & ecfg_lie[11:0]) != 12'b0);

endmodule

// ==== source/csr_save_regs.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_save_regs (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_req_t  csr_req,
    output csr_pkg::csr_data_t rdata
);

    localparam int IDX_W = $clog2(`CSR_SAVE_COUNT);

    csr_pkg::csr_data_t save_q [`CSR_SAVE_COUNT];

    logic [`CSR_NUM_W-1:0] sel_off;
    logic [IDX_W-1:0]      idx;
    logic                  hit;

    // wraps to a large value below SAVE0, so one compare covers both ends
    assign sel_off = csr_req.num - `CSR_SAVE0;
    assign hit     = (sel_off < `CSR_SAVE_COUNT);
    assign idx     = sel_off[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CSR_SAVE_COUNT; i++)
                save_q[i] <= '0;
        end else if (csr_req.we && hit) begin
            save_q[idx] <= (csr_req.wmask & csr_req.wvalue) | (~csr_req.wmask & save_q[idx]);
        end
    end

    assign rdata = hit ? save_q[idx] : '0;

endmodule

// ==== source/csr_timer.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_req_t  csr_req,
    output csr_pkg::csr_data_t rdata,
    output logic               timer_int,
    output logic [63:0]        counter,
    output csr_pkg::csr_data_t counter_id
);

    csr_pkg::csr_data_t tid;
    logic               tcfg_en;
    logic               tcfg_periodic;
    logic [29:0]        tcfg_initval;
    csr_pkg::csr_data_t timer_cnt;
    csr_pkg::csr_data_t tcfg_word;
    csr_pkg::csr_data_t wr_word;
    logic               tid_we, tcfg_we, ticlr_we;
    logic               timer_hit;

    assign tid_we   = csr_req.we && (csr_req.num == csr_pkg::NUM_TID);
    assign tcfg_we  = csr_req.we && (csr_req.num == csr_pkg::NUM_TCFG);
    assign ticlr_we = csr_req.we && (csr_req.num == csr_pkg::NUM_TICLR);

    assign wr_word   = (csr_req.wmask & csr_req.wvalue) | (~csr_req.wmask & rdata);
    assign timer_hit = tcfg_en && (timer_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset)
            tid <= '0;
        else if (tid_we)
            tid <= wr_word;
    end

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_we)
            tcfg_en <= wr_word[`CSR_TCFG_EN];
    end

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tcfg_periodic <= wr_word[`CSR_TCFG_PERIODIC];
            tcfg_initval  <= wr_word[`CSR_TCFG_INITVAL];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= `TIMER_IDLE;
        end else if (tcfg_we && wr_word[`CSR_TCFG_EN]) begin
            timer_cnt <= {wr_word[`CSR_TCFG_INITVAL], 2'b00}; // initval * 4
        end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 1'b1; // one-shot falls through to idle
        end
    end

    // sticky, hit wins over clear
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (timer_hit)
            timer_int <= 1'b1;
        else if (ticlr_we && wr_word[`CSR_TICLR_CLR])
            timer_int <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            counter <= '0;
        else
            counter <= counter + 64'd1;
    end

    always_comb begin
        tcfg_word = '0;
        tcfg_word[`CSR_TCFG_EN]       = tcfg_en;
        tcfg_word[`CSR_TCFG_PERIODIC] = tcfg_periodic;
        tcfg_word[`CSR_TCFG_INITVAL]  = tcfg_initval;
    end

    always_comb begin
        case (csr_req.num)
            csr_pkg::NUM_TID:  rdata = tid;
            csr_pkg::NUM_TCFG: rdata = tcfg_word;
            csr_pkg::NUM_TVAL: rdata = timer_cnt;
            default:           rdata = '0; // ticlr included
        endcase
    end

    assign counter_id = tid;

endmodule

// ==== source/csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_req_t  csr_req,
    input  csr_pkg::exc_info_t exc,
    output csr_pkg::csr_data_t csr_rvalue,
    output csr_pkg::csr_data_t ex_entry,
    output csr_pkg::csr_data_t ex_era,
    output logic               has_int,
    output logic [63:0]        counter,
    output csr_pkg::csr_data_t counter_id
);

    csr_pkg::csr_data_t exc_rdata;
    csr_pkg::csr_data_t save_rdata;
    csr_pkg::csr_data_t timer_rdata;
    logic               timer_int;

    csr_exc_regs u_exc_regs (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .exc       (exc),
        .timer_int (timer_int),
        .rdata     (exc_rdata),
        .ex_entry  (ex_entry),
        .ex_era    (ex_era),
        .has_int   (has_int)
    );

    csr_save_regs u_save_regs (
        .clk     (clk),
        .reset   (reset),
        .csr_req (csr_req),
        .rdata   (save_rdata)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .rdata      (timer_rdata),
        .timer_int  (timer_int),
        .counter    (counter),
        .counter_id (counter_id)
    );

    // banks return zero for numbers they do not own
    assign csr_rvalue = exc_rdata | save_rdata | timer_rdata;

endmodule

// ==== tests/csr_file_tb.sv ====
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_file_tb;

    localparam int longest_test_cycles = 1000;
    localparam int timeout_cycles      = 4 * longest_test_cycles;

    logic               clk;
    logic               reset;
    csr_pkg::csr_req_t  csr_req;
    csr_pkg::exc_info_t exc;
    csr_pkg::csr_data_t csr_rvalue;
    csr_pkg::csr_data_t ex_entry;
    csr_pkg::csr_data_t ex_era;
    csr_pkg::csr_data_t counter_id;
    logic               has_int;
    logic [63:0]        counter;

    int          n_checks;
    int          n_errors;
    int          n_tests_ok;
    int          n_tests_bad;
    int          errors_at_start;
    string       cur_test;
    logic [31:0] rng_state;
    logic [31:0] last_exc_pc;

    csr_file u_dut (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .exc        (exc),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .ex_era     (ex_era),
        .has_int    (has_int),
        .counter    (counter),
        .counter_id (counter_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("run timed out after %0d cycles, a test is stuck", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        errors_at_start = n_errors;
    endtask

    task automatic end_test();
        if (n_errors == errors_at_start) begin
            n_tests_ok++;
            $display("test %s passed", cur_test);
        end else begin
            n_tests_bad++;
            $display("test %s failed with %0d mismatches", cur_test, n_errors - errors_at_start);
        end
    endtask

    // one-cycle write that lands at the second edge
    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(posedge clk);
        #1;
        csr_req.we     = 1'b1;
        csr_req.num    = csr_pkg::csr_num_e'(num);
        csr_req.wmask  = mask;
        csr_req.wvalue = value;
        @(posedge clk);
        #1;
        csr_req.we = 1'b0;
    endtask

    task automatic read_csr(input logic [13:0] num, output logic [31:0] val);
        @(posedge clk);
        #1;
        csr_req.we  = 1'b0;
        csr_req.num = csr_pkg::csr_num_e'(num);
        #2;
        val = csr_rvalue;
    endtask

    task automatic raise_exc(input csr_pkg::ecode_e code, input logic [8:0] sub,
                             input logic [31:0] pc, input logic [31:0] vaddr);
        @(posedge clk);
        #1;
        exc.ex       = 1'b1;
        exc.ecode    = code;
        exc.esubcode = sub;
        exc.pc       = pc;
        exc.vaddr    = vaddr;
        @(posedge clk);
        #1;
        exc.ex = 1'b0;
        last_exc_pc = pc;
    endtask

    task automatic wait_for_int(input int max_cycles);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(posedge clk);
            #2;
            if (has_int)
                seen = 1'b1;
        end
        if (!seen) begin
            n_errors++;
            $display("%s: has_int never rose within %0d cycles", cur_test, max_cycles);
        end
    endtask

    task automatic check_entry(input logic [5:0] code, input logic [31:0] pc,
                               input logic [31:0] badv);
        logic [31:0] got;
        read_csr(`CSR_CRMD, got);
        check("crmd plv/ie", 3'b000, got[2:0]);
        read_csr(`CSR_PRMD, got);
        check("prmd pplv/pie", 3'b111, got[2:0]);
        read_csr(`CSR_ERA, got);
        check("era", pc, got);
        read_csr(`CSR_ESTAT, got);
        check("estat ecode", code, got[`CSR_ESTAT_ECODE]);
        read_csr(`CSR_BADV, got);
        check("badv", badv, got);
    endtask

    task automatic test_masked_writes();
        logic [31:0] shadow [5];
        logic [13:0] nums [5];
        logic [31:0] r, mask, value, got;
        int          sel;
        begin_test("masked_writes");
        for (int i = 0; i < 4; i++)
            nums[i] = `CSR_SAVE0 + i;
        nums[4] = `CSR_TID;
        for (int i = 0; i < 5; i++)
            shadow[i] = '0; // all zero after reset
        for (int k = 0; k < 24; k++) begin
            next_rand(r);
            sel = r % 5;
            next_rand(mask);
            next_rand(value);
            write_csr(nums[sel], mask, value);
            shadow[sel] = (value & mask) | (shadow[sel] & ~mask);
            read_csr(nums[sel], got);
            check("readback", shadow[sel], got);
            check("counter_id", shadow[4], counter_id);
        end
        read_csr(14'h020, got);
        check("unowned number", 32'h0, got);
        end_test();
    endtask

    task automatic test_exception_entry();
        logic [31:0] eentry_val;
        eentry_val = 32'h1c00_8abc;
        begin_test("exception_entry");
        write_csr(`CSR_CRMD, 32'h7, 32'h7); // plv 3, ie 1
        write_csr(`CSR_EENTRY, 32'hffff_ffff, eentry_val);
        check("ex_entry", eentry_val & ~32'h3f, ex_entry);
        raise_exc(csr_pkg::EXC_ALE, 9'd0, 32'h1c00_1234, 32'h0000_0a03);
        check_entry(`ECODE_ALE, 32'h1c00_1234, 32'h0000_0a03);
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        raise_exc(csr_pkg::EXC_ADE, `ESUBCODE_ADEF, 32'h1c00_2002, 32'hdead_beef);
        check_entry(`ECODE_ADE, 32'h1c00_2002, 32'h1c00_2002); // fetch fault reports pc
        end_test();
    endtask

    task automatic test_exception_return();
        logic [31:0] prmd, crmd, era;
        begin_test("exception_return");
        @(posedge clk);
        #1;
        exc.ertn = 1'b1;
        @(posedge clk);
        #1;
        exc.ertn = 1'b0;
        read_csr(`CSR_PRMD, prmd);
        read_csr(`CSR_CRMD, crmd);
        check("prmd kept", 3'b111, prmd[2:0]);
        check("restored plv/ie", 3'b111, crmd[2:0]);
        read_csr(`CSR_ERA, era);
        check("era", last_exc_pc, era);
        check("ex_era", last_exc_pc, ex_era);
        end_test();
    endtask

    task automatic test_oneshot_timer();
        logic [29:0] initval;
        logic [31:0] got;
        initval = 30'd5;
        begin_test("oneshot_timer");
        write_csr(`CSR_ECFG, 32'h1 << 11, 32'h1 << 11);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        check("has_int idle", 1'b0, has_int);
        write_csr(`CSR_TCFG, 32'hffff_ffff, {initval, 2'b01});
        wait_for_int(4 * initval + 10);
        read_csr(`CSR_ESTAT, got);
        check("estat timer bit", 1'b1, got[11]);
        read_csr(`CSR_TVAL, got);
        check("tval idle", 32'hffff_ffff, got);
        repeat (5) @(posedge clk);
        read_csr(`CSR_TVAL, got);
        check("tval stays idle", 32'hffff_ffff, got);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        check("has_int after clear", 1'b0, has_int);
        read_csr(`CSR_ESTAT, got);
        check("estat bit cleared", 1'b0, got[11]);
        end_test();
    endtask

    task automatic test_periodic_timer();
        logic [29:0] initval;
        logic [31:0] t1, t2;
        logic [63:0] prev;
        initval = 30'd8;
        begin_test("periodic_timer");
        write_csr(`CSR_TCFG, 32'hffff_ffff, {initval, 2'b11});
        read_csr(`CSR_TVAL, t1);
        repeat (3) @(posedge clk);
        read_csr(`CSR_TVAL, t2);
        check("tval decreasing", 1'b1, t2 < t1);
        wait_for_int(4 * initval + 10);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        check("has_int after clear", 1'b0, has_int);
        wait_for_int(4 * initval + 10); // next period
        @(posedge clk);
        #2;
        prev = counter;
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            #2;
            check("counter increasing", 1'b1, counter > prev);
            prev = counter;
        end
        end_test();
    endtask

    initial begin
        csr_req     = '0;
        exc         = '0;
        reset       = 1'b1;
        n_checks    = 0;
        n_errors    = 0;
        n_tests_ok  = 0;
        n_tests_bad = 0;
        rng_state   = 32'd16;
        last_exc_pc = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_masked_writes();
        test_exception_entry();
        test_exception_return();
        test_oneshot_timer();
        test_periodic_timer();

        $display("tests passed %0d failed %0d, checks %0d, mismatches %0d",
                 n_tests_ok, n_tests_bad, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== csr_file.f ====
+incdir+include
source/csr_pkg.sv
source/csr_exc_regs.sv
source/csr_save_regs.sv
source/csr_timer.sv
source/csr_file.sv
tests/csr_file_tb.sv
